/* design/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

`define LC3B_WIDTH 16
`define LC3B_NREGS 8
`define LC3B_RESET_PC 16'h0000

// Fetches of the same self-branch that mark the end of a program
`define LC3B_HALT_FETCHES 2

`endif

/* design/lc3b_types.sv */
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'h0, op_add  = 4'h1, op_ldb  = 4'h2, op_stb  = 4'h3,
        op_jsr  = 4'h4, op_and  = 4'h5, op_ldr  = 4'h6, op_str  = 4'h7,
        op_rti  = 4'h8, op_not  = 4'h9, op_ldi  = 4'ha, op_sti  = 4'hb,
        op_jmp  = 4'hc, op_shf  = 4'hd, op_lea  = 4'he, op_trap = 4'hf
    } lc3b_opcode;

    typedef logic [3:0]  lc3b_imm4;
    typedef logic [4:0]  lc3b_imm5;
    typedef logic [5:0]  lc3b_offset6;
    typedef logic [8:0]  lc3b_offset9;
    typedef logic [10:0] lc3b_offset11;

    typedef enum logic [2:0] {
        alu_add, alu_and, alu_not, alu_sll, alu_srl, alu_sra, alu_pass
    } lc3b_aluop;

    typedef enum logic [1:0] {
        pcmux_plus2, pcmux_bradd, pcmux_sr1
    } pcmux_sel_t;

    typedef enum logic [2:0] {
        alumux_sr2, alumux_sext5, alumux_adj6, alumux_zext4, alumux_sext6
    } alumux_sel_t;

    typedef enum logic [2:0] {
        regfilemux_alu, regfilemux_mdr, regfilemux_bradd, regfilemux_pc,
        regfilemux_mdr_byte
    } regfilemux_sel_t;

    typedef struct packed {
        logic            load_pc;
        logic            load_ir;
        logic            load_regfile;
        logic            load_mar;
        logic            load_mdr;
        logic            load_cc;
        logic            brmux_sel;     // 0 adj9, 1 adj11
        pcmux_sel_t      pcmux_sel;
        logic            storemux_sel;  // 0 sr2, 1 dest field
        logic            destmux_sel;   // 0 dest field, 1 R7
        alumux_sel_t     alumux_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            marmux_sel;    // 0 alu, 1 pc
        logic            mdrmux_sel;    // 0 alu, 1 bus read data
        lc3b_aluop       aluop;
        logic            mem_byte;
    } dp_ctrl_t;

    typedef struct packed {
        lc3b_opcode opcode;
        logic       inst4;
        logic       inst5;
        logic       inst11;
        logic       branch_enable;
    } dp_status_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [15:0] adr;
        logic [15:0] dat;
        logic [1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_t;

endpackage : lc3b_types

`default_nettype wire

/* design/ir.sv */
`timescale 1ns/1ps
`default_nettype none

module ir import lc3b_types::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         load,
    input  lc3b_word     in,
    output lc3b_opcode   opcode,
    output lc3b_reg      dest,
    output lc3b_reg      src1,
    output lc3b_reg      src2,
    output lc3b_imm4     imm4,
    output lc3b_imm5     imm5,
    output lc3b_offset6  offset6,
    output lc3b_offset9  offset9,
    output lc3b_offset11 offset11,
    output logic         inst4,
    output logic         inst5,
    output logic         inst11
);

    lc3b_word data;

    always_ff @(posedge clk) begin
        if (rst) begin
            data <= '0;
        end else if (load) begin
            data <= in;
        end
    end

    assign opcode   = lc3b_opcode'(data[15:12]);
    assign dest     = data[11:9];  // Also the nzp field of BR
    assign src1     = data[8:6];
    assign src2     = data[2:0];
    assign imm4     = data[3:0];
    assign imm5     = data[4:0];
    assign offset6  = data[5:0];
    assign offset9  = data[8:0];
    assign offset11 = data[10:0];
    assign inst4    = data[4];     // SHF direction
    assign inst5    = data[5];     // Immediate form, or SHF arithmetic
    assign inst11   = data[11];    // JSR versus JSRR

endmodule : ir

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_config.svh"

module regfile import lc3b_types::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  lc3b_word in,
    input  lc3b_reg  src_a,
    input  lc3b_reg  src_b,
    input  lc3b_reg  dest,
    output lc3b_word reg_a,
    output lc3b_word reg_b
);

    logic [`LC3B_WIDTH-1:0] regs [`LC3B_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LC3B_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= in;
        end
    end

    // Reads see the old value during a write to the same register
    assign reg_a = regs[src_a];
    assign reg_b = regs[src_b];

endmodule : regfile

`default_nettype wire

/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import lc3b_types::*; (
    input  lc3b_aluop aluop,
    input  lc3b_word  a,
    input  lc3b_word  b,
    output lc3b_word  f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];  // SHF amount from imm4

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            alu_sll: f = a << shamt;
            alu_srl: f = a >> shamt;
            alu_sra: f = lc3b_word'($signed(a) >>> shamt);
            default: f = b;     // Pass
        endcase
    end

endmodule : alu

`default_nettype wire

/* design/datapath.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_config.svh"

module datapath import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst,
    input  dp_ctrl_t   ctrl,
    input  lc3b_word   rdata,
    output lc3b_word   mem_adr,
    output lc3b_word   mem_wdata,
    output logic [1:0] mem_sel,
    output dp_status_t status
);

    lc3b_opcode   opcode;
    lc3b_reg      dest;
    lc3b_reg      src1;
    lc3b_reg      src2;
    lc3b_imm4     imm4;
    lc3b_imm5     imm5;
    lc3b_offset6  offset6;
    lc3b_offset9  offset9;
    lc3b_offset11 offset11;
    logic         inst4;
    logic         inst5;
    logic         inst11;

    lc3b_word pc;
    lc3b_word mar;
    lc3b_word mdr;
    lc3b_nzp  cc;
    lc3b_nzp  gencc;

    lc3b_word pc_plus2;
    lc3b_word adj6;
    lc3b_word adj9;
    lc3b_word adj11;
    lc3b_word sext5;
    lc3b_word sext6;
    lc3b_word zext4;
    lc3b_word bradd;
    lc3b_word reg_a;
    lc3b_word reg_b;
    lc3b_word alumux_out;
    lc3b_word alu_out;
    lc3b_word pcmux_out;
    lc3b_word regfilemux_out;
    lc3b_word mdr_byte;
    lc3b_reg  storemux_out;
    lc3b_reg  destmux_out;

    ir ir0 (
        .clk, .rst,
        .load(ctrl.load_ir),
        .in(mdr),
        .opcode, .dest, .src1, .src2,
        .imm4, .imm5, .offset6, .offset9, .offset11,
        .inst4, .inst5, .inst11
    );

    // Stores read the source register through port b
    assign storemux_out = ctrl.storemux_sel ? dest : src2;
    assign destmux_out  = ctrl.destmux_sel ? 3'b111 : dest;

    regfile regfile0 (
        .clk, .rst,
        .load(ctrl.load_regfile),
        .in(regfilemux_out),
        .src_a(src1),
        .src_b(storemux_out),
        .dest(destmux_out),
        .reg_a, .reg_b
    );

    assign sext5 = {{11{imm5[4]}}, imm5};
    assign sext6 = {{10{offset6[5]}}, offset6};
    assign zext4 = {12'b0, imm4};
    assign adj6  = {{9{offset6[5]}}, offset6, 1'b0};
    assign adj9  = {{6{offset9[8]}}, offset9, 1'b0};
    assign adj11 = {{4{offset11[10]}}, offset11, 1'b0};

    always_comb begin
        case (ctrl.alumux_sel)
            alumux_sext5: alumux_out = sext5;
            alumux_adj6:  alumux_out = adj6;
            alumux_zext4: alumux_out = zext4;
            alumux_sext6: alumux_out = sext6;
            default:      alumux_out = reg_b;
        endcase
    end

    alu alu0 (
        .aluop(ctrl.aluop),
        .a(reg_a),
        .b(alumux_out),
        .f(alu_out)
    );

    assign pc_plus2 = pc + 16'd2;
    assign bradd    = pc + (ctrl.brmux_sel ? adj11 : adj9);

    always_comb begin
        case (ctrl.pcmux_sel)
            pcmux_bradd: pcmux_out = bradd;
            pcmux_sr1:   pcmux_out = reg_a;
            default:     pcmux_out = pc_plus2;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `LC3B_RESET_PC;
            cc <= '0;
        end else begin
            if (ctrl.load_pc) begin
                pc <= pcmux_out;
            end
            if (ctrl.load_cc) begin
                cc <= gencc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.load_mar) begin
            mar <= ctrl.marmux_sel ? pc : alu_out;
        end
        if (ctrl.load_mdr) begin
            mdr <= ctrl.mdrmux_sel ? rdata : alu_out;
        end
    end

    assign mdr_byte = mar[0] ? {8'b0, mdr[15:8]} : {8'b0, mdr[7:0]};

    always_comb begin
        case (ctrl.regfilemux_sel)
            regfilemux_mdr:      regfilemux_out = mdr;
            regfilemux_bradd:    regfilemux_out = bradd;
            regfilemux_pc:       regfilemux_out = pc;
            regfilemux_mdr_byte: regfilemux_out = mdr_byte;
            default:             regfilemux_out = alu_out;
        endcase
    end

    assign gencc = {regfilemux_out[15], regfilemux_out == '0,
                    !regfilemux_out[15] && regfilemux_out != '0};

    // Bus request fields, byte lane picked by address bit 0
    assign mem_adr   = mar;
    assign mem_wdata = ctrl.mem_byte ? {2{mdr[7:0]}} : mdr;
    assign mem_sel   = ctrl.mem_byte ? (mar[0] ? 2'b10 : 2'b01) : 2'b11;

    assign status.opcode        = opcode;
    assign status.inst4         = inst4;
    assign status.inst5         = inst5;
    assign status.inst11        = inst11;
    assign status.branch_enable = |(dest & cc);

    // Word addresses from fetch, LDR and STR land on an even address
    a_word_aligned: assert property (@(posedge clk) disable iff (rst)
        ctrl.load_mar && !ctrl.mem_byte |=> !mem_adr[0]);

endmodule : datapath

`default_nettype wire

/* design/control.sv */
`timescale 1ns/1ps
`default_nettype none

module control import lc3b_types::*; (
    input  logic       clk,
    input  logic       rst,
    input  dp_status_t status,
    input  logic       ack,
    output dp_ctrl_t   ctrl,
    output logic       cyc,
    output logic       stb,
    output logic       we
);

    typedef enum logic [3:0] {
        s_fetch1, s_fetch2, s_fetch3, s_decode,
        s_alu, s_br, s_jmp, s_jsr, s_lea,
        s_calc_addr, s_ld_mem, s_ld_wb, s_st_mdr, s_st_mem
    } state_t;

    state_t     state;
    state_t     next_state;
    logic       byte_op;
    logic [5:0] loads;

    assign byte_op = status.opcode inside {op_ldb, op_stb};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_fetch1;
        end else begin
            state <= next_state;
        end
    end

    assign cyc = state inside {s_fetch2, s_ld_mem, s_st_mem};
    assign stb = cyc;
    assign we  = state == s_st_mem;

    always_comb begin
        ctrl       = '0;
        next_state = state;
        case (state)
            s_fetch1: begin
                ctrl.marmux_sel = 1'b1;
                ctrl.load_mar   = 1'b1;
                ctrl.load_pc    = 1'b1;  // PC + 2
                next_state      = s_fetch2;
            end
            s_fetch2: begin
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = ack;
                if (ack) next_state = s_fetch3;
            end
            s_fetch3: begin
                ctrl.load_ir = 1'b1;
                next_state   = s_decode;
            end
            s_decode: begin
                case (status.opcode)
                    op_add, op_and, op_not, op_shf: next_state = s_alu;
                    op_br:                          next_state = s_br;
                    op_jmp:                         next_state = s_jmp;
                    op_jsr:                         next_state = s_jsr;
                    op_lea:                         next_state = s_lea;
                    op_ldr, op_ldb, op_str, op_stb: next_state = s_calc_addr;
                    default:                        next_state = s_fetch1;
                endcase
            end
            s_alu: begin
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.alumux_sel   = status.inst5 ? alumux_sext5 : alumux_sr2;
                case (status.opcode)
                    op_add: ctrl.aluop = alu_add;
                    op_and: ctrl.aluop = alu_and;
                    op_not: ctrl.aluop = alu_not;
                    default: begin
                        ctrl.alumux_sel = alumux_zext4;
                        if (!status.inst4) ctrl.aluop = alu_sll;
                        else if (status.inst5) ctrl.aluop = alu_sra;
                        else ctrl.aluop = alu_srl;
                    end
                endcase
                next_state = s_fetch1;
            end
            s_br: begin
                ctrl.pcmux_sel = pcmux_bradd;
                ctrl.load_pc   = status.branch_enable;
                next_state     = s_fetch1;
            end
            s_jmp: begin
                ctrl.pcmux_sel = pcmux_sr1;
                ctrl.load_pc   = 1'b1;
                next_state     = s_fetch1;
            end
            s_jsr: begin
                ctrl.destmux_sel    = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc;
                ctrl.load_regfile   = 1'b1;
                ctrl.brmux_sel      = 1'b1;
                ctrl.pcmux_sel      = status.inst11 ? pcmux_bradd : pcmux_sr1;
                ctrl.load_pc        = 1'b1;
                next_state          = s_fetch1;
            end
            s_lea: begin
                ctrl.regfilemux_sel = regfilemux_bradd;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
                next_state          = s_fetch1;
            end
            s_calc_addr: begin
                ctrl.alumux_sel = byte_op ? alumux_sext6 : alumux_adj6;
                ctrl.aluop      = alu_add;
                ctrl.load_mar   = 1'b1;
                ctrl.mem_byte   = byte_op;
                if (status.opcode inside {op_str, op_stb}) next_state = s_st_mdr;
                else next_state = s_ld_mem;
            end
            s_ld_mem: begin
                ctrl.mem_byte   = byte_op;
                ctrl.mdrmux_sel = 1'b1;
                ctrl.load_mdr   = ack;
                if (ack) next_state = s_ld_wb;
            end
            s_ld_wb: begin
                ctrl.mem_byte       = byte_op;
                ctrl.regfilemux_sel = byte_op ? regfilemux_mdr_byte : regfilemux_mdr;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
                next_state          = s_fetch1;
            end
            s_st_mdr: begin
                ctrl.mem_byte     = byte_op;
                ctrl.storemux_sel = 1'b1;
                ctrl.alumux_sel   = alumux_sr2;
                ctrl.aluop        = alu_pass;
                ctrl.load_mdr     = 1'b1;
                next_state        = s_st_mem;
            end
            s_st_mem: begin
                ctrl.mem_byte = byte_op;
                if (ack) next_state = s_fetch1;
            end
            default: next_state = s_fetch1;
        endcase
    end

    assign loads = {ctrl.load_pc, ctrl.load_ir, ctrl.load_regfile,
                    ctrl.load_mar, ctrl.load_mdr, ctrl.load_cc};

    // The cycle ends in the state after ack
    a_drop_after_ack: assert property (@(posedge clk) disable iff (rst)
        cyc && ack |=> !cyc && !stb);

    // A write always follows the MDR load of the same store
    a_we_store: assert property (@(posedge clk) disable iff (rst)
        $rose(we) |-> $past(ctrl.load_mdr && !ctrl.mdrmux_sel));

    // Nothing moves while the slave stalls, and the request stays up
    a_hold_on_wait: assert property (@(posedge clk) disable iff (rst)
        cyc && !ack |-> loads == '0 ##1 cyc);

endmodule : control

`default_nettype wire

/* design/lc3b_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu import lc3b_types::*; (
    input  logic    clk,
    input  logic    rst,
    input  wb_rsp_t wb_i,
    output wb_req_t wb_o
);

    dp_ctrl_t   ctrl;
    dp_status_t status;
    lc3b_word   mem_adr;
    lc3b_word   mem_wdata;
    logic [1:0] mem_sel;
    logic       cyc;
    logic       stb;
    logic       we;

    control control0 (
        .clk, .rst,
        .status,
        .ack(wb_i.ack),
        .ctrl,
        .cyc, .stb, .we
    );

    datapath datapath0 (
        .clk, .rst,
        .ctrl,
        .rdata(wb_i.dat),
        .mem_adr, .mem_wdata, .mem_sel,
        .status
    );

    assign wb_o.cyc = cyc;
    assign wb_o.stb = stb;
    assign wb_o.we  = we;
    assign wb_o.adr = mem_adr;
    assign wb_o.dat = mem_wdata;
    assign wb_o.sel = mem_sel;

endmodule : lc3b_cpu

`default_nettype wire

/* test/lc3b_tb_program.svh */
`ifndef LC3B_TB_PROGRAM_SVH
`define LC3B_TB_PROGRAM_SVH

// Program table columns: byte address, word stored there
typedef struct packed {
    logic [15:0] adr;
    logic [15:0] dat;
} prog_entry_t;

// Store table columns: byte address, bus write data, byte lane select
typedef struct packed {
    logic [15:0] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
} store_entry_t;

localparam int PROG_LEN  = 58;
localparam int STORE_LEN = 17;
localparam logic [15:0] HALT_ADR = 16'h0062;  // BRnzp to itself

localparam prog_entry_t program_table [PROG_LEN] = '{
    '{16'h0000, 16'hec7f}, '{16'h0002, 16'hea8e}, '{16'h0004, 16'h6380}, '{16'h0006, 16'h6583},
    '{16'h0008, 16'h1642}, '{16'h000a, 16'h7740}, '{16'h000c, 16'h187b}, '{16'h000e, 16'h7941},
    '{16'h0010, 16'h5642}, '{16'h0012, 16'h7742}, '{16'h0014, 16'h586f}, '{16'h0016, 16'h7943},
    '{16'h0018, 16'h967f}, '{16'h001a, 16'h7744}, '{16'h001c, 16'hd644}, '{16'h001e, 16'h7745},
    '{16'h0020, 16'hd653}, '{16'h0022, 16'h7746}, '{16'h0024, 16'hd673}, '{16'h0026, 16'h7747},
    // Byte loads and stores
    '{16'h0028, 16'h2783}, '{16'h002a, 16'h7748}, '{16'h002c, 16'h2982}, '{16'h002e, 16'h3951},
    // Branches, each taken one skips a store to 0x015e
    '{16'h0030, 16'h3352}, '{16'h0032, 16'h0801}, '{16'h0034, 16'h794a}, '{16'h0036, 16'h0201},
    '{16'h0038, 16'h735f}, '{16'h003a, 16'h6582}, '{16'h003c, 16'h0a01}, '{16'h003e, 16'h734b},
    '{16'h0040, 16'h0401}, '{16'h0042, 16'h735f}, '{16'h0044, 16'h94bf}, '{16'h0046, 16'h0601},
    '{16'h0048, 16'h754c}, '{16'h004a, 16'h0801}, '{16'h004c, 16'h735f}, '{16'h004e, 16'h6780},
    // LEA, JMP, JSR, JSRR, then the final self-branch
    '{16'h0050, 16'h0801}, '{16'h0052, 16'h735f}, '{16'h0054, 16'he802}, '{16'h0056, 16'hc100},
    '{16'h0058, 16'h735f}, '{16'h005a, 16'h794d}, '{16'h005c, 16'h4803}, '{16'h005e, 16'he604},
    '{16'h0060, 16'h40c0}, '{16'h0062, 16'h0fff}, '{16'h0064, 16'h7f4e}, '{16'h0066, 16'hc1c0},
    '{16'h0068, 16'h7f4f}, '{16'h006a, 16'hc1c0}, '{16'h0100, 16'h8421}, '{16'h0102, 16'ha55a},
    '{16'h0104, 16'h0000}, '{16'h0106, 16'h7ffe}
};

localparam store_entry_t store_table [STORE_LEN] = '{
    '{16'h0120, 16'h041f, 2'b11}, '{16'h0122, 16'h841c, 2'b11},  // ADD reg, ADD imm
    '{16'h0124, 16'h0420, 2'b11}, '{16'h0126, 16'h0001, 2'b11},  // AND reg, AND imm
    '{16'h0128, 16'h7bde, 2'b11}, '{16'h012a, 16'h4210, 2'b11},  // NOT, LSHF
    '{16'h012c, 16'h1084, 2'b11}, '{16'h012e, 16'hf084, 2'b11},  // RSHFL, RSHFA
    '{16'h0130, 16'h00a5, 2'b11}, '{16'h0131, 16'h5a5a, 2'b10},  // LDB high, STB odd
    '{16'h0132, 16'h2121, 2'b01}, '{16'h0134, 16'h005a, 2'b11},  // STB even
    '{16'h0136, 16'h8421, 2'b11}, '{16'h0138, 16'hffff, 2'b11},
    '{16'h013a, 16'h005a, 2'b11}, '{16'h013c, 16'h005e, 2'b11},  // LEA value, JSR link
    '{16'h013e, 16'h0062, 2'b11}                                 // JSRR link
};

`endif

/* test/lc3b_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lc3b_config.svh"

module lc3b_tb import lc3b_types::*; ();

    `include "lc3b_tb_program.svh"

    localparam int     CLK_PERIOD  = 100;
    localparam int     MEM_WORDS   = 32768;
    localparam longint WATCHDOG_NS = longint'(PROG_LEN) * 40 * 6 * CLK_PERIOD;

    logic        clk;
    logic        rst;
    wb_req_t     req;
    wb_rsp_t     rsp;
    logic [15:0] mem [MEM_WORDS];
    logic [31:0] lfsr;
    logic        busy;
    int unsigned waits_left;
    int unsigned draw;
    logic        first_seen;
    int          errors;
    int          store_count;
    int          access_count;
    int          halt_fetches;

    lc3b_cpu dut0 (
        .clk,
        .rst,
        .wb_i(rsp),
        .wb_o(req)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [15:0] fill_word(input int unsigned a);
        return 16'(a * 32'h9e37) ^ 16'h5a5a;  // Odd multiplier keeps every word distinct
    endfunction

    task draw_wait_states(output int unsigned n);
        n = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            n = (n << 1) | lfsr[0];
        end
    endtask

    task serve_request;
        rsp.ack <= 1'b1;
        if (req.we) begin
            if (req.sel[0]) mem[req.adr[15:1]][7:0] = req.dat[7:0];
            if (req.sel[1]) mem[req.adr[15:1]][15:8] = req.dat[15:8];
        end else begin
            rsp.dat <= mem[req.adr[15:1]];
        end
    endtask

    task check_store;
        store_entry_t want;
        if (store_count >= STORE_LEN) begin
            $display("Fail at %0d ns: extra store of %h to %h", $time, req.dat, req.adr);
            errors++;
        end else begin
            want = store_table[store_count];
            if (req.adr !== want.adr || req.dat !== want.dat || req.sel !== want.sel) begin
                $display("Fail at %0d ns: store %0d: %h sel %b at %h, expected %h sel %b at %h",
                         $time, store_count, req.dat, req.sel, req.adr,
                         want.dat, want.sel, want.adr);
                errors++;
            end
        end
        store_count++;
    endtask

    task report_counts;
        $display("Summary: %0d of %0d stores, %0d bus accesses, %0d errors",
                 store_count, STORE_LEN, access_count, errors);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Memory model with zero to three wait states per access
    always @(posedge clk) begin
        if (rst) begin
            rsp        <= '0;
            busy       <= 1'b0;
            waits_left <= 0;
        end else if (rsp.ack) begin
            rsp.ack <= 1'b0;  // One ack per request
            busy    <= 1'b0;
        end else if (req.cyc && req.stb) begin
            if (!busy) begin
                draw_wait_states(draw);
                busy <= 1'b1;
            end else begin
                draw = waits_left;
            end
            if (draw == 0) begin
                serve_request();
            end else begin
                waits_left <= draw - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && req.cyc) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                if (req.adr !== `LC3B_RESET_PC || req.sel !== 2'b11 || req.we !== 1'b0) begin
                    $display("Fail at %0d ns: first request adr %h sel %b we %b",
                             $time, req.adr, req.sel, req.we);
                    errors++;
                end
            end
            if (req.we && req.sel == 2'b00) begin
                $display("Fail at %0d ns: write to %h with no byte lane selected",
                         $time, req.adr);
                errors++;
            end
            if (rsp.ack) begin
                access_count++;
                if (req.we) begin
                    check_store();
                end else if (req.adr == HALT_ADR) begin
                    halt_fetches++;
                end
            end
        end
    end

    initial begin
        rst          = 1'b1;
        rsp          = '0;
        lfsr         = 32'h10bd;
        busy         = 1'b0;
        waits_left   = 0;
        draw         = 0;
        first_seen   = 1'b0;
        errors       = 0;
        store_count  = 0;
        access_count = 0;
        halt_fetches = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = fill_word(a);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            mem[program_table[i].adr[15:1]] = program_table[i].dat;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (req.cyc !== 1'b0 || req.stb !== 1'b0) begin
            $display("Fail at %0d ns: cyc %b stb %b after reset", $time, req.cyc, req.stb);
            errors++;
        end
        wait (halt_fetches == `LC3B_HALT_FETCHES);
        @(negedge clk);
        if (store_count != STORE_LEN) begin
            $display("Fail at %0d ns: %0d stores seen, %0d expected",
                     $time, store_count, STORE_LEN);
            errors++;
        end
        report_counts();
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the program did not reach its final branch within %0d ns",
                 WATCHDOG_NS);
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule : lc3b_tb

`default_nettype wire

/* files.f */
+incdir+design
+incdir+test
design/lc3b_types.sv
design/ir.sv
design/regfile.sv
design/alu.sv
design/datapath.sv
design/control.sv
design/lc3b_cpu.sv
test/lc3b_tb.sv
